// ==== md_pkg.sv ====
// Shared widths, download index codes and cheat-code layout for the cartridge host
package md_pkg;

	//////////////////////////////
	// CPU side
	localparam int CPU_AW  = 23; // Word address, bits 23:1
	localparam int BANK_W  = 5;
	localparam int N_BANKS = 8;  // One per 512 KB window
	localparam int MASK_W  = 11; // ROM size mask, bits 23:13

	//////////////////////////////
	// Host download bus
	localparam int DL_AW    = 25;
	localparam int DL_DW    = 16;
	localparam int DL_IDX_W = 8;

	localparam logic [DL_IDX_W-1:0] IDX_CODE     = '1; // Cheat codes
	localparam logic [5:0]          IDX_ROM_MAX  = 6'd1;
	localparam int                  IDX_CART_BIT = 6;  // Set for a cartridge ROM

	// Region letter in the cartridge header
	localparam logic [DL_AW-1:0] HDR_REGION_ADDR = 25'h1F0;

	//////////////////////////////
	// Cheat code
	// Fields are big endian words as sent by the host
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// Loader fills words, consumers read fields
	typedef union packed {
		logic [7:0][15:0] words;
		cheat_code_t      fields;
	} cheat_code_u;

endpackage

// ==== dl_bus_if.sv ====
// Host download bus between the top level and the download-side blocks
`timescale 1ns/1ps

interface dl_bus_if;
	import md_pkg::*;

	logic                active; // Level for the whole download
	logic [DL_IDX_W-1:0] index;
	logic                wr;     // One-cycle strobe per word
	logic [DL_AW-1:0]    addr;   // Byte address, always even
	logic [DL_DW-1:0]    data;

	// Driven from the top-level ports
	modport source (
		output active, index, wr, addr, data
	);

	// No back-pressure, every strobe is taken in its own cycle
	modport sink (
		input active, index, wr, addr, data
	);

endinterface

// ==== header_snoop.sv ====
// Classifies ROM downloads and records cartridge mode and ROM size mask
`timescale 1ns/1ps

module header_snoop (
	input  logic                      clk_sys,
	input  logic                      reset,
	dl_bus_if.sink                    dl,
	output logic                      rom_loading,
	output logic                      cart_mode,
	output logic [md_pkg::MASK_W-1:0] rom_mask
);
	import md_pkg::*;

	logic rom_wr;
	logic cart_wr;
	logic addr_zero;

	// Index 0 is a plain ROM, index 1 and the cart bit variants too
	assign rom_loading = dl.active && (dl.index[5:0] <= IDX_ROM_MAX);

	assign rom_wr    = rom_loading && dl.wr;
	assign cart_wr   = rom_wr && dl.index[IDX_CART_BIT];
	assign addr_zero = (dl.addr == '0);

	//////////////////////////////
	// Cartridge mode
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_mode <= 1'b0;
		end else if (rom_wr) begin
			cart_mode <= dl.index[IDX_CART_BIT];
		end
	end

	//////////////////////////////
	// Size mask
	// Highest address bits seen give a power-of-two mask,
	// the first word of a new image starts it over
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_mask <= '0;
		end else if (cart_wr) begin
			if (addr_zero) begin
				rom_mask <= '0;
			end else begin
				rom_mask <= rom_mask | dl.addr[23:13]; // Address bits 23:13
			end
		end
	end

endmodule

// ==== region_ctrl.sv ====
// Console region select from header or OSD, with a held reset request on change
`timescale 1ns/1ps

module region_ctrl #(
	parameter int REGION_HOLD_W = 16
) (
	input  logic       clk_sys,
	input  logic       reset,
	dl_bus_if.sink     dl,
	input  logic       rom_loading,
	input  logic [1:0] region_opt,  // 0 = auto, else region + 1
	output logic [1:0] region,
	output logic       region_rst
);
	import md_pkg::*;

	logic [1:0]               region_req;
	logic [1:0]               region_new;
	logic                     hdr_region_wr;
	logic                     hold_clr;
	logic [REGION_HOLD_W-1:0] hold_cnt;

	assign hdr_region_wr = rom_loading && dl.wr && (dl.addr == HDR_REGION_ADDR);

	//////////////////////////////
	// Header request
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region_req <= 2'd0;
		end else if (hdr_region_wr) begin
			case (dl.data[7:0])
				"J":     region_req <= 2'd0; // Japan
				"U":     region_req <= 2'd1; // America
				default: region_req <= 2'd2; // Europe and the rest
			endcase
		end
	end

	// OSD override wins over the header
	assign region_new = (region_opt != 2'd0) ? region_opt - 2'd1 : region_req;
	assign hold_clr   = (region != region_new);

	//////////////////////////////
	// Region and hold counter
	// Counter restarts on every change, reset request stays up until it saturates
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region     <= 2'd0;
			hold_cnt   <= '0;
			region_rst <= 1'b1;
		end else begin
			region     <= region_new;
			region_rst <= hold_clr || !(&hold_cnt);
			if (hold_clr) begin
				hold_cnt <= '0;
			end else if (!(&hold_cnt)) begin
				hold_cnt <= hold_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== bank_mapper.sv ====
// Page-register bank mapper translating CPU addresses to masked ROM addresses
`timescale 1ns/1ps

module bank_mapper (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      rom_loading,
	input  logic [md_pkg::MASK_W-1:0] rom_mask,
	input  logic                      page_ce_n,   // Page-register window select
	input  logic                      cpu_rnw,
	input  logic [md_pkg::CPU_AW-1:0] cpu_addr,    // Bits 23:1
	input  logic [15:0]               cpu_wdata,
	output logic [md_pkg::CPU_AW-1:0] rom_addr     // Bits 23:1
);
	import md_pkg::*;

	logic [BANK_W-1:0] bank_reg [N_BANKS];
	logic              page_ce_q;
	logic              page_fall;
	logic              big_rom;
	logic              page_wr;
	logic [2:0]        reg_sel;
	logic [2:0]        win_sel;

	assign reg_sel = cpu_addr[2:0];   // A3:A1
	assign win_sel = cpu_addr[20:18]; // A21:A19, 512 KB window

	// Mask bits 23:22 set only for images above 4 MB
	assign big_rom = |rom_mask[MASK_W-1 -: 2];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_ce_q <= 1'b1;
		end else begin
			page_ce_q <= page_ce_n;
		end
	end

	assign page_fall = page_ce_q && !page_ce_n;

	// Register 0 is fixed, first window always sees bank 0
	assign page_wr = page_fall && !cpu_rnw && (reg_sel != 3'd0) && big_rom;

	//////////////////////////////
	// Bank registers
	always_ff @(posedge clk_sys) begin
		if (reset || rom_loading) begin
			for (int i = 0; i < N_BANKS; i++) begin
				bank_reg[i] <= BANK_W'(i); // Identity map
			end
		end else if (page_wr) begin
			bank_reg[reg_sel] <= cpu_wdata[BANK_W-1:0];
		end
	end

	//////////////////////////////
	// Address translation
	// Mask covers 23:13, bits below are always passed
	assign rom_addr = {bank_reg[win_sel], cpu_addr[17:0]} & {rom_mask, 12'hFFF};

endmodule

// ==== cheat_loader.sv ====
// Assembles 128-bit cheat codes from download words and strobes each one out
`timescale 1ns/1ps

module cheat_loader (
	input  logic                clk_sys,
	input  logic                reset,
	dl_bus_if.sink              dl,
	output logic                code_strobe,
	output md_pkg::cheat_code_u code,
	output logic                code_clear   // First word of a new code list
);
	import md_pkg::*;

	logic       code_wr;
	logic [3:0] offset;
	logic [2:0] word_sel;

	assign code_wr = dl.active && (dl.index == IDX_CODE) && dl.wr;
	assign offset  = dl.addr[3:0];

	// Pairs go flags, address, compare, replace, each low word first.
	// Pair p lands in field 3-p, bit 1 picks the half
	assign word_sel = {~offset[3:2], offset[1]};

	assign code_clear = code_wr && (dl.addr == '0);

	//////////////////////////////
	// Word assembly
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			code.words[word_sel] <= dl.data;
		end
	end

	// Replace top word completes the code
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_strobe <= 1'b0;
		end else begin
			code_strobe <= code_wr && (offset == 4'd14);
		end
	end

endmodule

// ==== md_cart_host.sv ====
// Cartridge host top level joining download bus, header snoop, region, mapper and cheats
`timescale 1ns/1ps

module md_cart_host #(
	parameter int REGION_HOLD_W = 16
) (
	input  logic                        clk_sys,
	input  logic                        reset,

	// Host download bus
	input  logic                        dl_active,
	input  logic [md_pkg::DL_IDX_W-1:0] dl_index,
	input  logic                        dl_wr,
	input  logic [md_pkg::DL_AW-1:0]    dl_addr,
	input  logic [md_pkg::DL_DW-1:0]    dl_data,

	input  logic [1:0]                  region_opt,

	// CPU page-register window
	input  logic                        page_ce_n,
	input  logic                        cpu_rnw,
	input  logic [md_pkg::CPU_AW-1:0]   cpu_addr,
	input  logic [15:0]                 cpu_wdata,

	output logic [md_pkg::CPU_AW-1:0]   rom_addr,
	output logic                        rom_loading,
	output logic                        cart_mode,
	output logic [1:0]                  region,
	output logic                        region_rst,

	// Cheat codes
	output logic                        code_strobe,
	output logic                        code_clear,
	output logic [31:0]                 code_flags,
	output logic [31:0]                 code_address,
	output logic [31:0]                 code_compare,
	output logic [31:0]                 code_replace
);
	import md_pkg::*;

	logic [MASK_W-1:0] rom_mask;
	cheat_code_u       code;

	dl_bus_if dl ();

	// Plain ports onto the bus, source side
	assign dl.active = dl_active;
	assign dl.index  = dl_index;
	assign dl.wr     = dl_wr;
	assign dl.addr   = dl_addr;
	assign dl.data   = dl_data;

	header_snoop u_header_snoop (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl.sink),
		.rom_loading (rom_loading),
		.cart_mode   (cart_mode),
		.rom_mask    (rom_mask)
	);

	region_ctrl #(
		.REGION_HOLD_W (REGION_HOLD_W)
	) u_region_ctrl (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl.sink),
		.rom_loading (rom_loading),
		.region_opt  (region_opt),
		.region      (region),
		.region_rst  (region_rst)
	);

	bank_mapper u_bank_mapper (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.rom_loading (rom_loading),
		.rom_mask    (rom_mask),
		.page_ce_n   (page_ce_n),
		.cpu_rnw     (cpu_rnw),
		.cpu_addr    (cpu_addr),
		.cpu_wdata   (cpu_wdata),
		.rom_addr    (rom_addr)
	);

	cheat_loader u_cheat_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl.sink),
		.code_strobe (code_strobe),
		.code        (code),
		.code_clear  (code_clear)
	);

	// Field view of the assembled code
	assign code_flags   = code.fields.flags;
	assign code_address = code.fields.address;
	assign code_compare = code.fields.compare;
	assign code_replace = code.fields.replace;

endmodule

// ==== tb_md_cart_host.sv ====
// Directed testbench for the cartridge host covering region, size mask, bank mapper and cheats
`timescale 1ns/1ps

module tb_md_cart_host;
	import md_pkg::*;

	localparam int                  RST_PULSE   = 16;   // 15 hold cycles plus clearing cycle
	localparam int                  CYCLE_LIMIT = 3000; // Tests need about 300 cycles
	localparam logic [CPU_AW-1:0]   PAGE_BASE   = 23'h509878; // Byte address 0xA130F0
	localparam logic [DL_IDX_W-1:0] IDX_CART    = 8'h40;
	localparam logic [31:0]         SEED        = 32'h28b77fe7;

	logic                clk_sys;
	logic                reset;
	logic                dl_active;
	logic [DL_IDX_W-1:0] dl_index;
	logic                dl_wr;
	logic [DL_AW-1:0]    dl_addr;
	logic [DL_DW-1:0]    dl_data;
	logic [1:0]          region_opt;
	logic                page_ce_n;
	logic                cpu_rnw;
	logic [CPU_AW-1:0]   cpu_addr;
	logic [15:0]         cpu_wdata;
	logic [CPU_AW-1:0]   rom_addr;
	logic                rom_loading;
	logic                cart_mode;
	logic [1:0]          region;
	logic                region_rst;
	logic                code_strobe;
	logic                code_clear;
	logic [31:0]         code_flags;
	logic [31:0]         code_address;
	logic [31:0]         code_compare;
	logic [31:0]         code_replace;

	int err_cnt;
	int chk_cnt;
	int cycle_cnt;

	// Reference state
	logic              exp_cart;
	logic [MASK_W-1:0] exp_mask;
	logic [BANK_W-1:0] exp_bank [N_BANKS];
	cheat_code_u       exp_code;

	md_cart_host #(
		.REGION_HOLD_W (4)
	) u_md_cart_host (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl_active),
		.dl_index     (dl_index),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.region_opt   (region_opt),
		.page_ce_n    (page_ce_n),
		.cpu_rnw      (cpu_rnw),
		.cpu_addr     (cpu_addr),
		.cpu_wdata    (cpu_wdata),
		.rom_addr     (rom_addr),
		.rom_loading  (rom_loading),
		.cart_mode    (cart_mode),
		.region       (region),
		.region_rst   (region_rst),
		.code_strobe  (code_strobe),
		.code_clear   (code_clear),
		.code_flags   (code_flags),
		.code_address (code_address),
		.code_compare (code_compare),
		.code_replace (code_replace)
	);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt == CYCLE_LIMIT) begin
			$display("Timeout: run stopped after %0d cycles without finishing", cycle_cnt);
			$display("TB FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// Compare tasks
	task automatic check_bit(input string name, input logic exp, input logic act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_region(input string name, input logic [1:0] exp, input logic [1:0] act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input logic [CPU_AW-1:0] exp,
			input logic [CPU_AW-1:0] act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_code(input string name, input cheat_code_u exp, input cheat_code_u act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	//////////////////////////////
	// Bus helpers
	function automatic logic rom_index(input logic [DL_IDX_W-1:0] idx);
		return idx[5:0] <= 6'd1;
	endfunction

	task automatic start_load(input logic [DL_IDX_W-1:0] idx);
		dl_index  = idx;
		dl_active = 1'b1;
		if (rom_index(idx)) begin
			for (int i = 0; i < N_BANKS; i++) begin
				exp_bank[i] = BANK_W'(i); // Identity while loading
			end
		end
	endtask

	task automatic end_load();
		dl_active = 1'b0;
	endtask

	// One strobe, then a gap cycle; checks the cheat pulses on every word
	task automatic dl_write(input logic [DL_AW-1:0] addr, input logic [DL_DW-1:0] data);
		logic rom_wr;
		logic code_wr;
		rom_wr  = dl_active && rom_index(dl_index);
		code_wr = dl_active && (dl_index == IDX_CODE);
		dl_wr   = 1'b1;
		dl_addr = addr;
		dl_data = data;
		#1;
		check_bit("rom_loading", rom_wr, rom_loading);
		check_bit("code_clear", code_wr && (addr == '0), code_clear);
		@(negedge clk_sys);
		check_bit("code_strobe", code_wr && (addr[3:0] == 4'd14), code_strobe);
		dl_wr = 1'b0;
		if (rom_wr) begin
			exp_cart = dl_index[IDX_CART_BIT];
			if (dl_index[IDX_CART_BIT]) begin
				exp_mask = (addr == '0) ? '0 : (exp_mask | addr[23:13]);
			end
		end
		if (code_wr) begin
			case (addr[3:1]) // Low half first, flags to replace
				3'd0: exp_code.fields.flags[15:0]    = data;
				3'd1: exp_code.fields.flags[31:16]   = data;
				3'd2: exp_code.fields.address[15:0]  = data;
				3'd3: exp_code.fields.address[31:16] = data;
				3'd4: exp_code.fields.compare[15:0]  = data;
				3'd5: exp_code.fields.compare[31:16] = data;
				3'd6: exp_code.fields.replace[15:0]  = data;
				default: exp_code.fields.replace[31:16] = data;
			endcase
		end
		@(negedge clk_sys);
		check_bit("code_strobe", 1'b0, code_strobe);
	endtask

	task automatic load_rom(input logic [DL_AW-1:0] last_addr);
		start_load(IDX_CART);
		dl_write('0, DL_DW'($urandom));
		dl_write(last_addr, DL_DW'($urandom));
		end_load();
		@(negedge clk_sys);
	endtask

	//////////////////////////////
	// CPU side helpers
	task automatic page_write(input logic [2:0] sel, input logic [15:0] data);
		cpu_addr  = PAGE_BASE | CPU_AW'(sel);
		cpu_rnw   = 1'b0;
		cpu_wdata = data;
		page_ce_n = 1'b0;
		@(negedge clk_sys);
		page_ce_n = 1'b1;
		cpu_rnw   = 1'b1;
		if (sel != 3'd0 && |exp_mask[MASK_W-1 -: 2]) begin
			exp_bank[sel] = data[BANK_W-1:0];
		end
		@(negedge clk_sys);
	endtask

	// One random address in each 512 KB window
	task automatic check_windows();
		logic [CPU_AW-1:0] a;
		for (int w = 0; w < N_BANKS; w++) begin
			a         = CPU_AW'($urandom);
			a[20:18]  = 3'(w);
			cpu_addr  = a;
			@(negedge clk_sys);
			check_addr("rom_addr", {exp_bank[w], a[17:0]} & {exp_mask, 12'hFFF}, rom_addr);
		end
	endtask

	//////////////////////////////
	// Region helpers
	task automatic wait_region(input logic [1:0] exp);
		int n;
		n = 0;
		while (region !== exp && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (region !== exp) begin
			err_cnt++;
			$display("Region never switched to %0d within 8 cycles, still %0d", exp, region);
		end
	endtask

	task automatic check_rst_pulse(input int len);
		for (int i = 0; i < len; i++) begin
			check_bit("region_rst", 1'b1, region_rst);
			@(negedge clk_sys);
		end
		check_bit("region_rst", 1'b0, region_rst);
	endtask

	//////////////////////////////
	// Tests
	task automatic test_region_header();
		start_load(IDX_CART);
		dl_write('0, DL_DW'($urandom));
		dl_write(HDR_REGION_ADDR, {8'h20, "U"});
		end_load();
		wait_region(2'd1);
		check_rst_pulse(RST_PULSE);
		start_load(IDX_CART);
		dl_write('0, DL_DW'($urandom));
		dl_write(HDR_REGION_ADDR, {8'h20, "E"});
		end_load();
		wait_region(2'd2);
		check_rst_pulse(RST_PULSE);
	endtask

	task automatic test_osd_override();
		region_opt = 2'd1;
		wait_region(2'd0);
		check_rst_pulse(RST_PULSE);
		start_load(IDX_CART);
		dl_write(HDR_REGION_ADDR, {8'h20, "U"}); // Header says America
		end_load();
		repeat (2) @(negedge clk_sys);
		check_region("region", 2'd0, region);
		check_bit("region_rst", 1'b0, region_rst);
		region_opt = 2'd0;
		wait_region(2'd1);
		check_rst_pulse(RST_PULSE);
	endtask

	task automatic test_small_rom();
		logic [CPU_AW-1:0] a;
		load_rom(25'h1FFFFE); // 2 MB
		check_bit("cart_mode", 1'b1, cart_mode);
		for (int i = 0; i < 6; i++) begin
			a        = CPU_AW'($urandom);
			cpu_addr = a;
			@(negedge clk_sys);
			check_addr("rom_addr", a & {11'h0FF, 12'hFFF}, rom_addr);
		end
		page_write(3'd3, 16'h0000); // Bank bits 1:0 still visible here
		page_write(3'd1, 16'h0000);
		check_windows();
	endtask

	task automatic test_bank_switch();
		load_rom(25'h4FFFFE); // 5 MB
		check_bit("cart_mode", exp_cart, cart_mode);
		check_windows();
		for (int r = 1; r < N_BANKS; r++) begin
			page_write(3'(r), 16'($urandom));
			check_windows();
		end
		page_write(3'd0, 16'h001F); // Every visible bank bit would flip
		check_windows();
		load_rom(25'h4FFFFE);
		check_windows();
	endtask

	task automatic test_cheat();
		cheat_code_u act;
		start_load(IDX_CODE);
		for (int k = 0; k < 8; k++) begin
			dl_write(DL_AW'(2 * k), DL_DW'($urandom));
		end
		end_load();
		act.fields = '{code_flags, code_address, code_compare, code_replace};
		check_code("code", exp_code, act);
		// Plain ROM load must leave the code alone
		start_load(8'h00);
		dl_write('0, DL_DW'($urandom));
		dl_write(25'd14, DL_DW'($urandom));
		end_load();
		act.fields = '{code_flags, code_address, code_compare, code_replace};
		check_code("code", exp_code, act);
		check_bit("cart_mode", 1'b0, cart_mode);
	endtask

	initial begin
		clk_sys    = 1'b0;
		reset      = 1'b1;
		dl_active  = 1'b0;
		dl_index   = '0;
		dl_wr      = 1'b0;
		dl_addr    = '0;
		dl_data    = '0;
		region_opt = 2'd0;
		page_ce_n  = 1'b1;
		cpu_rnw    = 1'b1;
		cpu_addr   = '0;
		cpu_wdata  = '0;
		err_cnt    = 0;
		chk_cnt    = 0;
		cycle_cnt  = 0;
		exp_cart   = 1'b0;
		exp_mask   = '0;
		exp_code   = '0;
		for (int i = 0; i < N_BANKS; i++) begin
			exp_bank[i] = BANK_W'(i);
		end
		void'($urandom(SEED));

		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		check_region("region", 2'd0, region);
		check_bit("code_strobe", 1'b0, code_strobe);
		check_rst_pulse(RST_PULSE);

		test_region_header();
		test_osd_override();
		test_small_rom();
		test_bank_switch();
		test_cheat();

		$display("Run complete: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
md_pkg.sv
dl_bus_if.sv
header_snoop.sv
region_ctrl.sv
bank_mapper.sv
cheat_loader.sv
md_cart_host.sv
tb_md_cart_host.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --timescale 1ns/1ps --top-module tb_md_cart_host -f tb.f \
	-o sim_tb > sim.log 2>&1 && ./obj_dir/sim_tb >> sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; } || \
	grep -q "TB PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
